// ==== Bender.yml ====
package:
  name: rv_front_end

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rvPkg.sv
      - hdl/stageReg.sv
      - hdl/fetchStage.sv
      - hdl/instrDecoder.sv
      - hdl/decodeStage.sv
      - hdl/frontEnd.sv
  - target: test
    include_dirs:
      - hdl
      - testbench
    files:
      - testbench/frontEndTb.sv

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module decodeStage import rvPkg::*; (
	input  logic             clk,
	input  logic             nrst,
	input  logic             stall,
	input  logic             flush,
	input  logic             exceptionPending,
	input  fetchPayloadT     payload,
	input  logic             payloadValid,
	output logic             valid,
	output logic [`XLEN-1:0] pc,
	output logic [`REGW-1:0] rs1, rs2, rd, shamt,
	output logic [`XLEN-1:0] iImm, sImm, bImm, uImm, jImm,
	output logic [`CSRW-1:0] csrAddr,
	output logic [`XLEN-1:0] csrImm,
	output logic [2:0]       funct3,
	output logic             misaligned,
	output logic             we,
	output aluFnT            aluFn,
	output fnUnitT           fnUnit,
	output bSelT             bSel,
	output pcSelT            pcSel,
	output memOpT            memOp,
	output mulDivOpT         mulDivOp,
	output logic             bneq, branch, jal, jalr, lui, auipc,
	output logic             ecall, system, illegal
);

	fetchPayloadT     q;
	logic [`XLEN-1:0] w;      // Registered instruction word
	opcodeT           opcode;
	fnUnitT           decFnUnit;
	pcSelT            decPcSel;
	memOpT            decMemOp;
	logic             decWe, decBneq, decBranch, decJal, decJalr;
	logic             decLui, decAuipc, decEcall, decSystem, decIllegal;

	stageReg #(.payloadT(fetchPayloadT)) fetchToDecode (
		.clk(clk), .nrst(nrst), .stall(stall), .flush(flush),
		.d(payload), .dValid(payloadValid), .q(q), .valid(valid)
	);

	assign w          = q.instr;
	assign pc         = q.pc;
	assign misaligned = valid & q.misaligned;
	assign opcode     = opcodeT'(w[6:0]);
	assign rd         = w[11:7];
	assign funct3     = w[14:12];
	assign rs1        = w[19:15];
	assign rs2        = w[24:20];
	assign shamt      = w[24:20];
	assign csrAddr    = w[31:20];
	assign csrImm     = {{(`XLEN-5){1'b0}}, w[19:15]}; // uimm, zero extended

	// Sign-extended immediates
	assign iImm = {{(`XLEN-12){w[31]}}, w[31:20]};
	assign sImm = {{(`XLEN-12){w[31]}}, w[31:25], w[11:7]};
	assign bImm = {{(`XLEN-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
	assign uImm = {w[31:12], 12'b0};
	assign jImm = {{(`XLEN-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

	instrDecoder dec (
		.opcode(opcode), .funct3(funct3), .funct7(w[31:25]), .funct12(w[31:20]),
		.exceptionPending(exceptionPending),
		.we(decWe), .aluFn(aluFn), .fnUnit(decFnUnit), .bSel(bSel), .pcSel(decPcSel),
		.memOp(decMemOp), .mulDivOp(mulDivOp), .bneq(decBneq), .branch(decBranch),
		.jal(decJal), .jalr(decJalr), .lui(decLui), .auipc(decAuipc),
		.ecall(decEcall), .system(decSystem), .illegal(decIllegal)
	);

	// A bubble issues nothing
	assign we      = valid & decWe;
	assign bneq    = valid & decBneq;
	assign branch  = valid & decBranch;
	assign jal     = valid & decJal;
	assign jalr    = valid & decJalr;
	assign lui     = valid & decLui;
	assign auipc   = valid & decAuipc;
	assign ecall   = valid & decEcall;
	assign system  = valid & decSystem;
	assign illegal = valid & decIllegal;
	assign fnUnit  = valid ? decFnUnit : fuNone;
	assign pcSel   = valid ? decPcSel : pcNext;
	assign memOp   = valid ? decMemOp : memNone;

	// Illegal slot never writes back, a flushed slot is empty next cycle
	aIllegalNoWe : assert property (@(posedge clk) disable iff (!nrst) illegal |-> !we)
		else $error("illegal instruction with write enable");
	aFlushBubble : assert property (@(posedge clk) disable iff (!nrst) flush |=> !valid)
		else $error("flush did not leave a bubble");

endmodule

// ==== hdl/fetchStage.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module fetchStage import rvPkg::*; (
	input  logic              clk,
	input  logic              nrst,
	input  logic              stall,
	input  logic              redirect,   // Taken branch, jump or trap
	input  logic [`XLEN-1:0]  redirectPc,
	input  logic [`XLEN-1:0]  instr,      // Word from instruction memory
	output logic [`XLEN-1:0]  fetchPc,
	output fetchPayloadT      payload
);

	logic [`XLEN-1:0] pcReg;
	logic [`XLEN-1:0] pcPlus4;
	logic             misaligned;

	assign pcPlus4 = pcReg + `XLEN'd4;

	// Redirect beats stall so a flushed slot never waits
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			pcReg <= `RESETPC;
		else if (redirect)
			pcReg <= redirectPc;
		else if (!stall)
			pcReg <= pcPlus4;
	end

	assign fetchPc = pcReg;

	// Only a redirect target can land off a word boundary
	assign misaligned = |pcReg[1:0];

	always_comb
	begin
		payload.instr      = instr;
		payload.pc         = pcReg;
		payload.misaligned = misaligned;
	end

	// Stepping by four never changes the low bits
	property incKeepsAlign;
		@(posedge clk) disable iff (!nrst)
		!redirect && !stall |=> fetchPc[1:0] == $past(fetchPc[1:0]);
	endproperty

	aIncKeepsAlign : assert property (incKeepsAlign)
		else $error("fetch increment changed PC alignment");

endmodule

// ==== hdl/frontEnd.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module frontEnd import rvPkg::*; (
	input  logic             clk,
	input  logic             nrst,
	input  logic             stall,            // Back-pressure from issue
	input  logic             redirect,
	input  logic [`XLEN-1:0] redirectPc,
	input  logic [`XLEN-1:0] instr,            // Same-cycle memory answer
	input  logic             exceptionPending,
	output logic [`XLEN-1:0] fetchPc,
	output logic             valid,
	output logic [`XLEN-1:0] pc,
	output logic [`REGW-1:0] rs1,
	output logic [`REGW-1:0] rs2,
	output logic [`REGW-1:0] rd,
	output logic [`REGW-1:0] shamt,
	output logic [`XLEN-1:0] iImm,
	output logic [`XLEN-1:0] sImm,
	output logic [`XLEN-1:0] bImm,
	output logic [`XLEN-1:0] uImm,
	output logic [`XLEN-1:0] jImm,
	output logic [`CSRW-1:0] csrAddr,
	output logic [`XLEN-1:0] csrImm,
	output logic [2:0]       funct3,
	output logic             misaligned,
	output logic             we,
	output aluFnT            aluFn,
	output fnUnitT           fnUnit,
	output bSelT             bSel,
	output pcSelT            pcSel,
	output memOpT            memOp,
	output mulDivOpT         mulDivOp,
	output logic             bneq,
	output logic             branch,
	output logic             jal,
	output logic             jalr,
	output logic             lui,
	output logic             auipc,
	output logic             ecall,
	output logic             system,
	output logic             illegal
);

	fetchPayloadT fetchPayload; // Word, PC and alignment flag

	fetchStage fetch (
		.*,
		.payload(fetchPayload)
	);

	// Every fetched word is a real slot, redirect kills the one in flight
	decodeStage decode (
		.*,
		.flush(redirect),
		.payload(fetchPayload),
		.payloadValid(1'b1)
	);

endmodule

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module instrDecoder import rvPkg::*; (
	input  opcodeT           opcode,
	input  logic [2:0]       funct3,
	input  logic [6:0]       funct7,
	input  logic [`CSRW-1:0] funct12,
	input  logic             exceptionPending,
	output logic             we,        // Register file write
	output aluFnT            aluFn,
	output fnUnitT           fnUnit,
	output bSelT             bSel,
	output pcSelT            pcSel,
	output memOpT            memOp,
	output mulDivOpT         mulDivOp,
	output logic             bneq,      // Invert the compare result
	output logic             branch,
	output logic             jal,
	output logic             jalr,
	output logic             lui,
	output logic             auipc,
	output logic             ecall,
	output logic             system,
	output logic             illegal
);

	logic weRaw; // Before exception gating

	// Shared by op and opImm, alt selects sub or sra
	function automatic aluFnT aluBase(input logic [2:0] f3, input logic alt);
		aluFnT fn;
		case (f3)
			3'b000:  fn = alt ? aluSub : aluAdd;
			3'b001:  fn = aluSll;
			3'b010:  fn = aluSlt;
			3'b011:  fn = aluSltu;
			3'b100:  fn = aluXor;
			3'b101:  fn = alt ? aluSra : aluSrl;
			3'b110:  fn = aluOr;
			default: fn = aluAnd;
		endcase
		return fn;
	endfunction

	always_comb
	begin
		weRaw    = 1'b0;
		aluFn    = aluAdd;
		fnUnit   = fnUnitT'(fuAlu);
		bSel     = bSelReg;
		pcSel    = pcNext;
		memOp    = memNone;
		mulDivOp = mulDivOpT'(funct3);
		bneq     = 1'b0;
		branch   = 1'b0;
		jal      = 1'b0;
		jalr     = 1'b0;
		lui      = 1'b0;
		auipc    = 1'b0;
		ecall    = 1'b0;
		system   = 1'b0;
		illegal  = 1'b0;
		case (opcode)
			opcLoad:
			begin
				fnUnit = fuLsu;
				bSel   = bSelImm; // Address is rs1 + iImm
				weRaw  = 1'b1;
				case (funct3)
					3'b000:  memOp = memLb;
					3'b001:  memOp = memLh;
					3'b010:  memOp = memLw;
					3'b100:  memOp = memLbu;
					3'b101:  memOp = memLhu;
					default: illegal = 1'b1;
				endcase
			end
			opcStore:
			begin
				fnUnit = fuLsu;
				bSel   = bSelImm;
				case (funct3)
					3'b000:  memOp = memSb;
					3'b001:  memOp = memSh;
					3'b010:  memOp = memSw;
					default: illegal = 1'b1;
				endcase
			end
			opcBranch:
			begin
				fnUnit = fuBranch;
				branch = 1'b1;
				pcSel  = pcBranch;
				bneq   = funct3[0]; // bne, bge, bgeu
				case (funct3[2:1])
					2'b00:   aluFn = aluSub;
					2'b10:   aluFn = aluSlt;
					2'b11:   aluFn = aluSltu;
					default: illegal = 1'b1;
				endcase
			end
			opcJal:
			begin
				jal   = 1'b1;
				pcSel = pcJal;
				bSel  = bSelPc4; // Link value
				aluFn = aluPassB;
				weRaw = 1'b1;
			end
			opcJalr:
			begin
				jalr    = 1'b1;
				pcSel   = pcJalr;
				bSel    = bSelPc4;
				aluFn   = aluPassB;
				weRaw   = 1'b1;
				illegal = funct3 != 3'b000;
			end
			opcOpImm:
			begin
				bSel  = bSelImm;
				weRaw = 1'b1;
				aluFn = aluBase(funct3, funct3 == 3'b101 && funct7[5]);
				if (funct3 == 3'b001)
					illegal = funct7 != 7'b0000000;
				else if (funct3 == 3'b101)
					illegal = funct7 != 7'b0000000 && funct7 != 7'b0100000;
			end
			opcOp:
			begin
				weRaw = 1'b1;
				if (funct7 == 7'b0000001)
					fnUnit = fuMulDiv; // M extension
				else if (funct7 == 7'b0000000)
					aluFn = aluBase(funct3, 1'b0);
				else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))
					aluFn = aluBase(funct3, 1'b1);
				else
					illegal = 1'b1;
			end
			opcLui:
			begin
				lui   = 1'b1;
				bSel  = bSelImm;
				aluFn = aluPassB;
				weRaw = 1'b1;
			end
			opcAuipc:
			begin
				auipc = 1'b1;
				bSel  = bSelImm; // Operand A is the PC
				weRaw = 1'b1;
			end
			opcSystem:
			begin
				system = 1'b1;
				case (funct3)
					3'b000:
					begin
						fnUnit = fuNone;
						if (funct12 == '0)
							ecall = 1'b1;
						else
							illegal = 1'b1; // ebreak and xret not supported
					end
					3'b100: illegal = 1'b1;
					default:
					begin
						fnUnit = fuCsr; // csrrw .. csrrci
						bSel   = bSelCsr;
						aluFn  = aluPassB;
						weRaw  = 1'b1;
					end
				endcase
			end
			default: illegal = 1'b1;
		endcase
		if (illegal)
		begin
			weRaw  = 1'b0;
			memOp  = memNone;
			fnUnit = fuNone;
		end
	end

	assign we = weRaw & ~exceptionPending;

endmodule

// ==== hdl/rvDefines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path and address width
`define XLEN 32

// Register file index width, 32 architectural registers
`define REGW 5

// Width of the CSR address field in instr[31:20]
`define CSRW 12

// Where fetch starts after reset
`define RESETPC 32'h0000_0000

`endif

// ==== hdl/rvPkg.sv ====
`include "rvDefines.svh"

package rvPkg;

	// RV32I major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		opcLoad   = 7'b0000011,
		opcStore  = 7'b0100011,
		opcBranch = 7'b1100011,
		opcJal    = 7'b1101111,
		opcJalr   = 7'b1100111,
		opcOpImm  = 7'b0010011,
		opcOp     = 7'b0110011,
		opcLui    = 7'b0110111,
		opcAuipc  = 7'b0010111,
		opcSystem = 7'b1110011
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd,
		aluPassB // Operand B straight through
	} aluFnT;

	typedef enum logic [2:0] {fuAlu, fuBranch, fuLsu, fuMulDiv, fuCsr, fuNone} fnUnitT;

	typedef enum logic [3:0] {
		memNone, memLb, memLh, memLw, memLbu, memLhu, memSb, memSh, memSw
	} memOpT;

	// Encoded as funct3 of the M extension
	typedef enum logic [2:0] {
		mdMul, mdMulh, mdMulhsu, mdMulhu, mdDiv, mdDivu, mdRem, mdRemu
	} mulDivOpT;

	typedef enum logic [1:0] {bSelReg, bSelImm, bSelPc4, bSelCsr} bSelT;

	typedef enum logic [1:0] {pcNext, pcBranch, pcJal, pcJalr} pcSelT;

	// What fetch hands to decode
	typedef struct packed {
		logic [`XLEN-1:0] instr;
		logic [`XLEN-1:0] pc;
		logic             misaligned; // PC not word aligned
	} fetchPayloadT;

endpackage

// ==== hdl/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    nrst,
	input  logic    stall,   // Hold everything
	input  logic    flush,   // Kill the slot, beats stall
	input  payloadT d,
	input  logic    dValid,
	output payloadT q,
	output logic    valid
);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			q     <= '0;
			valid <= 1'b0;
		end
		else if (flush)
			valid <= 1'b0; // Bubble, stale payload stays
		else if (!stall)
		begin
			q     <= d;
			valid <= dValid;
		end
	end

	// A stalled slot must not move or change
	property holdOnStall;
		@(posedge clk) disable iff (!nrst)
		stall && !flush |=> $stable(q) && $stable(valid);
	endproperty

	aHoldOnStall : assert property (holdOnStall)
		else $error("stageReg changed while stalled");

endmodule

// ==== tb.f ====
+incdir+hdl
+incdir+testbench
hdl/rvPkg.sv
hdl/stageReg.sv
hdl/fetchStage.sv
hdl/instrDecoder.sv
hdl/decodeStage.sv
hdl/frontEnd.sv
testbench/frontEndTb.sv

// ==== testbench/refDecode.svh ====
`ifndef REF_DECODE_SVH
`define REF_DECODE_SVH

// ALU function of op and opImm, alt picks sub or sra
function automatic aluFnT aluOf(input logic [2:0] f3, input logic alt);
	aluFnT fn;
	case (f3)
		3'd0: fn = alt ? aluSub : aluAdd;
		3'd1: fn = aluSll;
		3'd2: fn = aluSlt;
		3'd3: fn = aluSltu;
		3'd4: fn = aluXor;
		3'd5: fn = alt ? aluSra : aluSrl;
		3'd6: fn = aluOr;
		default: fn = aluAnd;
	endcase
	return fn;
endfunction

// Expected control word, same bit order as ctrlWord in the testbench
function automatic logic [27:0] refCtrl(input logic [31:0] w, input logic pend, input logic v);
	logic [2:0] f3;
	logic [6:0] f7;
	logic       wr, bq, br, jl, jr, lu, au, ec, sy, il;
	aluFnT      fn;
	fnUnitT     unit;
	bSelT       bs;
	pcSelT      ps;
	memOpT      mo;
	f3 = w[14:12];
	f7 = w[31:25];
	{wr, bq, br, jl, jr, lu, au, ec, sy, il} = '0;
	fn = aluAdd;
	unit = fuAlu;
	bs = bSelReg;
	ps = pcNext;
	mo = memNone;
	case (w[6:0])
		opcLoad:
		begin
			unit = fuLsu;
			bs = bSelImm;
			wr = 1'b1;
			case (f3)
				3'd0: mo = memLb;
				3'd1: mo = memLh;
				3'd2: mo = memLw;
				3'd4: mo = memLbu;
				3'd5: mo = memLhu;
				default: il = 1'b1;
			endcase
		end
		opcStore:
		begin
			unit = fuLsu;
			bs = bSelImm;
			il = f3 > 3'd2;
			mo = (f3 == 3'd0) ? memSb : (f3 == 3'd1) ? memSh : memSw;
		end
		opcBranch:
		begin
			unit = fuBranch;
			br = 1'b1;
			ps = pcBranch;
			bq = f3[0]; // Inverted compare
			if (f3[2:1] == 2'b01)
				il = 1'b1;
			else if (f3[2])
				fn = f3[1] ? aluSltu : aluSlt;
			else
				fn = aluSub;
		end
		opcJal, opcJalr:
		begin
			jl = w[6:0] == opcJal;
			jr = !jl;
			ps = jl ? pcJal : pcJalr;
			bs = bSelPc4; // Link address
			fn = aluPassB;
			wr = 1'b1;
			il = jr && f3 != 3'd0;
		end
		opcOpImm:
		begin
			bs = bSelImm;
			wr = 1'b1;
			fn = aluOf(f3, f3 == 3'd5 && f7[5]);
			il = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
		end
		opcOp:
		begin
			wr = 1'b1;
			if (f7 == 7'h01)
				unit = fuMulDiv;
			else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
				fn = aluOf(f3, f7[5]);
			else
				il = 1'b1;
		end
		opcLui:
		begin
			lu = 1'b1;
			bs = bSelImm;
			fn = aluPassB;
			wr = 1'b1;
		end
		opcAuipc:
		begin
			au = 1'b1;
			bs = bSelImm;
			wr = 1'b1;
		end
		opcSystem:
		begin
			sy = 1'b1;
			if (f3 == 3'd0)
			begin
				unit = fuNone;
				ec = w[31:20] == 12'h000; // Anything else there is unsupported
				il = !ec;
			end
			else if (f3 == 3'd4)
				il = 1'b1;
			else
			begin
				unit = fuCsr;
				bs = bSelCsr;
				fn = aluPassB;
				wr = 1'b1;
			end
		end
		default: il = 1'b1;
	endcase
	if (il)
	begin
		wr = 1'b0;
		mo = memNone;
		unit = fuNone;
	end
	wr = wr & !pend & v;
	unit = v ? unit : fuNone; // Bubble
	ps = v ? ps : pcNext;
	mo = v ? mo : memNone;
	return {wr, fn, unit, bs, ps, mo, f3, {bq, br, jl, jr, lu, au, ec, sy, il} & {9{v}}};
endfunction

// Immediates by arithmetic shift of the packed fields
function automatic logic [31:0] immI(input logic [31:0] w);
	return $signed(w) >>> 20;
endfunction

function automatic logic [31:0] immS(input logic [31:0] w);
	return $signed({w[31:25], w[11:7], 20'b0}) >>> 20;
endfunction

function automatic logic [31:0] immB(input logic [31:0] w);
	return $signed({w[31], w[7], w[30:25], w[11:8], 20'b0}) >>> 19;
endfunction

function automatic logic [31:0] immU(input logic [31:0] w);
	return {w[31:12], 12'b0};
endfunction

function automatic logic [31:0] immJ(input logic [31:0] w);
	return $signed({w[31], w[19:12], w[20], w[30:21], 12'b0}) >>> 11;
endfunction

`endif

// ==== testbench/frontEndTb.sv ====
`timescale 1ns/1ps
`include "rvDefines.svh"

module frontEndTb import rvPkg::*; ();

	localparam int NUMCYCLES = 600;
	localparam int MEMWORDS  = 256; // Indexed by fetchPc[9:2]

	logic clk = 1'b0;
	logic nrst, stall, redirect, exceptionPending;
	logic [`XLEN-1:0] redirectPc, instr, fetchPc, pc;
	logic valid, misaligned, we, bneq, branch, jal, jalr, lui, auipc, ecall, system, illegal;
	logic [`REGW-1:0] rs1, rs2, rd, shamt;
	logic [`XLEN-1:0] iImm, sImm, bImm, uImm, jImm, csrImm;
	logic [`CSRW-1:0] csrAddr;
	logic [2:0] funct3;
	aluFnT aluFn;
	fnUnitT fnUnit;
	bSelT bSel;
	pcSelT pcSel;
	memOpT memOp;
	mulDivOpT mulDivOp;
	logic [27:0] ctrlWord;

	logic [31:0] imem [MEMWORDS]; // Instruction memory model
	logic [31:0] expPc, slotWord, slotPc;
	logic expValid, slotMis, timedOut;
	int seed, falls, errors, checks, stalls, redirects;

	`include "refDecode.svh"

	frontEnd dut (.*);

	assign ctrlWord = {we, aluFn, fnUnit, bSel, pcSel, memOp, mulDivOp,
		bneq, branch, jal, jalr, lui, auipc, ecall, system, illegal};

	always #10 clk = ~clk;

	always @(negedge clk)
		falls++;

	// Poll until n more falling edges have passed or the time budget runs out
	task automatic waitFall(input int n);
		int target;
		int budget;
		target = falls + n;
		budget = 0;
		while (falls < target && budget < 25 * n)
		begin
			#1;
			budget++;
		end
		if (falls < target)
		begin
			errors++;
			timedOut = 1'b1;
			$display("Timeout: clock stopped, no falling edge within %0d ns", budget);
		end
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("FAIL %s: expected %h, actual %h at %0t", name, exp, act, $time);
		end
	endtask

	// Legal RV32IM and CSR shapes mixed with raw words
	function automatic logic [31:0] randomWord();
		logic [31:0] w;
		int r;
		w = $urandom;
		r = $urandom % 4;
		case ($urandom % 12)
			0: w[6:0] = opcLoad;
			1: w[6:0] = opcStore;
			2: w[6:0] = opcBranch;
			3: w[6:0] = opcJal;
			4:
			begin
				w[6:0] = opcJalr;
				w[14:12] = 3'b000;
			end
			5:
			begin
				w[6:0] = opcOpImm;
				if (w[14:12] == 3'd1 || w[14:12] == 3'd5)
					w[31:25] = {1'b0, w[30], 5'b0}; // Shift encodings
			end
			6:
			begin
				w[6:0] = opcOp;
				w[31:25] = (r == 0) ? 7'h00 : (r == 1) ? 7'h01 : (r == 2) ? 7'h20 : w[31:25];
			end
			7: w[6:0] = r[0] ? opcLui : opcAuipc;
			8:
			begin
				w[6:0] = opcSystem;
				if (w[14:12] == 3'd0 && r != 0)
					w[31:20] = 12'h000; // Mostly ecall
			end
			default: w = w ^ {r[1:0], 30'b0}; // Raw random word
		endcase
		return w;
	endfunction

	// Expected state after the coming rising edge
	task automatic predict();
		if (redirect)
		begin
			expPc = redirectPc;
			expValid = 1'b0; // Stale payload stays
			redirects++;
		end
		else if (!stall)
		begin
			slotWord = imem[expPc[9:2]];
			slotPc = expPc;
			slotMis = |expPc[1:0];
			expValid = 1'b1;
			expPc = expPc + 32'd4;
		end
		else
			stalls++;
	endtask

	task automatic checkOutputs();
		compare("fetch pc", expPc, fetchPc);
		compare("decode valid", expValid, valid);
		compare("decode pc", slotPc, pc);
		compare("misaligned", expValid & slotMis, misaligned);
		compare("fields", {slotWord[19:15], slotWord[24:20], slotWord[11:7], slotWord[24:20],
			slotWord[14:12]}, {rs1, rs2, rd, shamt, funct3});
		compare("csr addr", slotWord[31:20], csrAddr);
		compare("csr imm", {27'b0, slotWord[19:15]}, csrImm);
		compare("i imm", immI(slotWord), iImm);
		compare("s imm", immS(slotWord), sImm);
		compare("b imm", immB(slotWord), bImm);
		compare("u imm", immU(slotWord), uImm);
		compare("j imm", immJ(slotWord), jImm);
		compare("control word", refCtrl(slotWord, exceptionPending, expValid), ctrlWord);
	endtask

	initial
	begin
		logic [31:0] target;
		seed = 8;
		void'($urandom(seed));
		{falls, errors, checks, stalls, redirects} = '0;
		timedOut = 1'b0;
		nrst = 1'b0;
		stall = 1'b0;
		redirect = 1'b0;
		redirectPc = '0;
		instr = '0;
		exceptionPending = 1'b0;
		for (int i = 0; i < MEMWORDS; i++)
			imem[i] = randomWord();
		expPc = `RESETPC;
		expValid = 1'b0;
		slotWord = '0; // Payload resets to zero
		slotPc = '0;
		slotMis = 1'b0;
		waitFall(3); // Reset held over three rising edges
		compare("reset fetch pc", `RESETPC, fetchPc);
		compare("reset valid", 32'd0, valid);
		compare("reset enables", 32'd0, {we, ecall, illegal, system, jal, jalr, branch});
		nrst = 1'b1;
		for (int cycle = 0; cycle < NUMCYCLES && !timedOut; cycle++)
		begin
			// Plain streaming first, then random stall, redirect and exceptions
			stall = cycle >= 20 && ($urandom % 4 == 0);
			redirect = cycle >= 20 && ($urandom % 12 == 0);
			exceptionPending = cycle >= 40 && ($urandom % 6 == 0);
			target = $urandom;
			if ($urandom % 3 != 0)
				target[1:0] = 2'b00;
			redirectPc = target;
			instr = imem[fetchPc[9:2]]; // Same-cycle memory answer
			predict();
			waitFall(1);
			if (!timedOut)
				checkOutputs();
		end
		$display("Checks %0d, errors %0d, stall cycles %0d, redirects %0d",
			checks, errors, stalls, redirects);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
